/* logic/decodePkg.sv */
package decodePkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int numLanes = 4;
    localparam int laneIdxW = $clog2(numLanes);
    localparam int addrW    = 32;
    localparam int instrW   = 32;
    localparam int countW   = 16;   // Instruction count of one run

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // First sixteen follow funct[4:1] of a data-processing word
    typedef enum logic [4:0] {
        opAnd = 5'd0,
        opEor,
        opSub,
        opRsb,
        opAdd,
        opAdc,
        opSbc,
        opRsc,
        opTst,
        opTeq,
        opCmp,
        opCmn,
        opOrr,
        opMov,
        opBic,
        opMvn,
        opMul = 5'd16,
        opDiv,
        opFadd,
        opLdrp,
        opLdrn,
        opStrp,
        opStrn
    } aluOpE;

    typedef enum logic [1:0] {
        clsDp     = 2'b00,
        clsMem    = 2'b01,
        clsBranch = 2'b10,
        clsFloat  = 2'b11
    } instrClassE;   // Instr[27:26]

    // Registered decode result of one lane
    typedef struct packed {
        logic [addrW-1:0] pc;
        logic             issue;
        logic [3:0]       flagW;    // NZCV write mask
        logic             pcs;
        logic             regW;
        logic             memW;
        logic             memToReg;
        logic             noWrite;
        logic             aluSrc;
        logic [1:0]       immSrc;
        logic [2:0]       regSrc;
        aluOpE            operation;
        logic             ms;       // Multi-cycle unit select
        logic             mCycleOp; // Divide when set
        logic             fps;
    } ctrlBundleT;

endpackage

/* logic/instrFetch.sv */
`timescale 1ns/10ps

module instrFetch import decodePkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic [addrW-1:0]    baseAddr,
    input  logic [countW-1:0]   instrCount,
    input  logic [instrW-1:0]   wbDatI,
    input  logic                wbAck,
    input  logic [numLanes-1:0] laneFull,
    input  logic                retired,
    output logic                busy,
    output logic                wbCyc,
    output logic                wbStb,
    output logic [addrW-1:0]    wbAdr,
    output logic [numLanes-1:0] laneLoad,
    output logic [instrW-1:0]   loadInstr,
    output logic [addrW-1:0]    loadPc
);

    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stDrain
    } fetchStateE;

    fetchStateE          state;
    logic                cycActive;
    logic                ackTaken;
    logic [addrW-1:0]    addr;
    logic [countW-1:0]   wordCount;
    logic [countW-1:0]   issuedCnt;
    logic [countW-1:0]   retiredCnt;
    logic [laneIdxW-1:0] ptr;      // Next lane in rotation

    assign ackTaken = cycActive && wbAck;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= stIdle;
            cycActive  <= 1'b0;
            ptr        <= '0;
            issuedCnt  <= '0;
            retiredCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start && instrCount != '0) begin
                        state      <= stRequest;
                        cycActive  <= 1'b1;   // All lanes drained while idle
                        issuedCnt  <= '0;
                        retiredCnt <= '0;
                    end
                end
                stRequest: begin
                    if (ackTaken) begin
                        cycActive <= 1'b0;
                        ptr       <= ptr + 1'b1;
                        issuedCnt <= issuedCnt + 1'b1;
                        if (issuedCnt + 1'b1 == wordCount)
                            state <= stDrain;
                    end else if (!cycActive && !laneFull[ptr]) begin
                        cycActive <= 1'b1;
                    end
                end
                stDrain: begin
                    if (retiredCnt == wordCount)
                        state <= stIdle;
                end
                default: state <= stIdle;
            endcase
            if (retired)
                retiredCnt <= retiredCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && start) begin
            addr      <= baseAddr;
            wordCount <= instrCount;
        end else if (ackTaken) begin
            addr <= addr + addrW'(4);
        end
    end

    assign busy      = (state != stIdle);
    assign wbCyc     = cycActive;
    assign wbStb     = cycActive;
    assign wbAdr     = addr;
    assign laneLoad  = ackTaken ? (numLanes'(1) << ptr) : '0;
    assign loadInstr = wbDatI;
    assign loadPc    = addr;

    // Address held until the slave acks
    assert property (@(posedge clk) disable iff (!rstN)
        (wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr)))
        else $error("wbAdr changed during a pending read");

    assert property (@(posedge clk) disable iff (!rstN)
        (laneLoad & laneFull) == '0)
        else $error("Load aimed at a full lane");

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import decodePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              load,
    input  logic [instrW-1:0] instr,
    input  logic [addrW-1:0]  pc,
    input  logic              take,
    output logic              full,
    output ctrlBundleT        bundle
);

    instrClassE  cls;
    logic [5:0]  funct;
    logic [3:0]  rd;
    logic        sBit;
    logic        branch;
    logic [1:0]  aluCtl;   // 11 data-processing, 01 memory offset, 00 plain add
    aluOpE       dpOp;
    logic        isCompare;
    logic        isLogical;

    logic [3:0]  flagW;
    logic        pcs;
    logic        regW;
    logic        memW;
    logic        memToReg;
    logic        noWrite;
    logic        aluSrc;
    logic [1:0]  immSrc;
    logic [2:0]  regSrc;
    aluOpE       operation;
    logic        ms;
    logic        mCycleOp;
    logic        fps;

    assign cls   = instrClassE'(instr[27:26]);
    assign funct = instr[25:20];
    assign rd    = instr[15:12];
    assign sBit  = funct[0];
    assign dpOp  = aluOpE'({1'b0, funct[4:1]});

    assign isCompare = dpOp inside {opTst, opTeq, opCmp, opCmn};
    assign isLogical = dpOp inside {opAnd, opEor, opTst, opTeq, opOrr, opMov, opBic, opMvn};

    ////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////

    always_comb begin
        branch   = 1'b0;
        memToReg = 1'b0;
        memW     = 1'b0;
        aluSrc   = 1'b1;
        immSrc   = 2'b10;
        regW     = 1'b0;
        regSrc   = 3'b001;
        aluCtl   = 2'b00;
        ms       = 1'b0;
        mCycleOp = 1'b0;
        fps      = 1'b0;
        case (cls)
            clsDp: begin
                aluCtl = 2'b11;
                immSrc = 2'b00;
                regSrc = 3'b000;
                aluSrc = funct[5];   // Immediate form
                regW   = 1'b1;
                if (!funct[5] && instr[7:4] == 4'b1001 && instr[24:21] == 4'b0000) begin
                    regW   = 1'b0;   // MUL
                    regSrc = 3'b100;
                    ms     = 1'b1;
                end
            end
            clsMem: begin
                aluCtl = 2'b01;
                immSrc = 2'b01;
                aluSrc = ~funct[5];
                if (!funct[0]) begin
                    memW   = 1'b1;   // STR
                    regSrc = 3'b010;
                end else if (funct == 6'b111111 && instr[7:4] == 4'b1111) begin
                    regSrc   = 3'b100;   // DIV
                    ms       = 1'b1;
                    mCycleOp = 1'b1;
                end else begin
                    memToReg = 1'b1;
                    regW     = 1'b1;
                    regSrc   = 3'b000;
                end
            end
            clsBranch: branch = 1'b1;
            clsFloat: begin
                if (funct[5:3] == 3'b100 && funct[1:0] == 2'b11) begin
                    fps    = 1'b1;   // FADDS
                    aluSrc = 1'b0;
                    regSrc = 3'b000;
                end
            end
        endcase
    end

    ////////////////////////////////////////
    // ALU decode
    ////////////////////////////////////////

    always_comb begin
        operation = opAdd;
        flagW     = 4'b0000;
        noWrite   = 1'b0;
        if (ms) begin
            operation = mCycleOp ? opDiv : opMul;
        end else if (fps) begin
            operation = opFadd;
        end else if (aluCtl == 2'b11) begin
            operation = dpOp;
            if (sBit)
                flagW = isLogical ? 4'b1110 : 4'b1111;
            if (isCompare) begin
                noWrite = 1'b1;
                if (!sBit)
                    operation = opAdd;   // Not a real compare without S
            end
        end else if (aluCtl == 2'b01) begin
            case ({funct[3], funct[0]})   // U, L
                2'b11:   operation = opLdrp;
                2'b10:   operation = opStrp;
                2'b01:   operation = opLdrn;
                default: operation = opStrn;
            endcase
        end
    end

    assign pcs = ((rd == 4'd15) && regW) || branch;

    always_ff @(posedge clk) begin
        if (!rstN)
            full <= 1'b0;
        else if (load)
            full <= 1'b1;
        else if (take)
            full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bundle <= '{pc: pc, issue: |instr, flagW: flagW, pcs: pcs, regW: regW,
                        memW: memW, memToReg: memToReg, noWrite: noWrite,
                        aluSrc: aluSrc, immSrc: immSrc, regSrc: regSrc,
                        operation: operation, ms: ms, mCycleOp: mCycleOp, fps: fps};
        end
    end

    // Fetch must never overwrite a held result
    assert property (@(posedge clk) disable iff (!rstN) !(load && full))
        else $error("Lane loaded while full");

endmodule

/* logic/retireCollector.sv */
`timescale 1ns/10ps

module retireCollector import decodePkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic [numLanes-1:0] laneFull,
    input  ctrlBundleT          laneBundle [numLanes],
    input  logic                ctrlReady,
    output logic [numLanes-1:0] laneTake,
    output logic                retired,
    output logic                ctrlValid,
    output ctrlBundleT          ctrlOut
);

    logic [laneIdxW-1:0] ptr;   // Oldest lane, same rotation as fetch
    logic                fire;

    ////////////////////////////////////////
    // Output mux
    ////////////////////////////////////////

    assign ctrlValid = laneFull[ptr];
    assign ctrlOut   = laneBundle[ptr];
    assign fire      = ctrlValid && ctrlReady;
    assign retired   = fire;
    assign laneTake  = fire ? (numLanes'(1) << ptr) : '0;

    always_ff @(posedge clk) begin
        if (!rstN)
            ptr <= '0;
        else if (fire)
            ptr <= ptr + 1'b1;
    end

    // Stalled output holds its data
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrlValid && !ctrlReady) |=> (ctrlValid && $stable(ctrlOut)))
        else $error("ctrlOut changed while stalled");

endmodule

/* logic/decodeTop.sv */
`timescale 1ns/10ps

module decodeTop import decodePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  logic [addrW-1:0]  baseAddr,
    input  logic [countW-1:0] instrCount,
    input  logic [instrW-1:0] wbDatI,
    input  logic              wbAck,
    input  logic              ctrlReady,
    output logic              busy,
    output logic              wbCyc,
    output logic              wbStb,
    output logic [addrW-1:0]  wbAdr,
    output logic              ctrlValid,
    output ctrlBundleT        ctrlOut
);

    logic [numLanes-1:0] laneFull;
    logic [numLanes-1:0] laneLoad;
    logic [numLanes-1:0] laneTake;
    logic                retired;
    logic [instrW-1:0]   loadInstr;
    logic [addrW-1:0]    loadPc;
    ctrlBundleT          laneBundle [numLanes];

    instrFetch fetch_i (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .baseAddr   (baseAddr),
        .instrCount (instrCount),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .laneFull   (laneFull),
        .retired    (retired),
        .busy       (busy),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .laneLoad   (laneLoad),
        .loadInstr  (loadInstr),
        .loadPc     (loadPc)
    );

    for (genvar i = 0; i < numLanes; i++) begin : genLanes
        controlUnit lane_i (
            .clk    (clk),
            .rstN   (rstN),
            .load   (laneLoad[i]),
            .instr  (loadInstr),
            .pc     (loadPc),
            .take   (laneTake[i]),
            .full   (laneFull[i]),
            .bundle (laneBundle[i])
        );
    end

    retireCollector collector_i (
        .clk        (clk),
        .rstN       (rstN),
        .laneFull   (laneFull),
        .laneBundle (laneBundle),
        .ctrlReady  (ctrlReady),
        .laneTake   (laneTake),
        .retired    (retired),
        .ctrlValid  (ctrlValid),
        .ctrlOut    (ctrlOut)
    );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam real halfPeriod = 10.0;   // 20 ns clock
    localparam int  resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Release just after an edge so the first active edge is clean
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

/* bench/decodeTb.sv */
`timescale 1ns/10ps

module decodeTb import decodePkg::*; ();

    localparam int totalWords = 64 + 8 + 10 + 4 + 64 + 8;
    localparam int cycleLimit = totalWords * 12 + 200;

    logic              clk;
    logic              rstN;
    logic              start;
    logic [addrW-1:0]  baseAddr;
    logic [countW-1:0] instrCount;
    logic [instrW-1:0] wbDatI;
    logic              wbAck;
    logic              ctrlReady;
    logic              busy;
    logic              wbCyc;
    logic              wbStb;
    logic [addrW-1:0]  wbAdr;
    logic              ctrlValid;
    ctrlBundleT        ctrlOut;

    logic [instrW-1:0] mem [1024];
    logic [31:0]       lcgState = 32'd89;
    logic [31:0]       busRnd;
    logic              waiting;
    logic [1:0]        waitLeft;
    logic              randomReady;
    logic [31:0]       progQ[$];
    ctrlBundleT        gotQ[$];
    int                cycleCnt;
    int                errorCount;
    int                testsPassed;
    int                testsFailed;

    clockGen clkGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    decodeTop decodeTop_i (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .baseAddr   (baseAddr),
        .instrCount (instrCount),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .ctrlReady  (ctrlReady),
        .busy       (busy),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .ctrlValid  (ctrlValid),
        .ctrlOut    (ctrlOut)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] dpWord(input logic [3:0] op, input logic imm,
                                           input logic s, input logic [3:0] rd);
        return {4'hE, 2'b00, imm, op, s, 4'h1, rd, imm ? 12'h0FF : 12'h002};
    endfunction

    // P set, B and W clear
    function automatic logic [31:0] memWord(input logic imm, input logic u, input logic l);
        return {4'hE, 2'b01, imm, 1'b1, u, 1'b0, 1'b0, l, 4'h1, 4'h3, 12'h010};
    endfunction

    // Expected bundle from the decode rules
    function automatic ctrlBundleT refDecode(input logic [31:0] w, input logic [31:0] pc);
        ctrlBundleT b;
        logic [3:0] opBits;
        logic       isMul;
        logic       isDiv;
        logic       isFadds;
        logic       isCmp;
        logic       isLogic;
        logic       branch;
        opBits  = w[24:21];
        isMul   = (w[27:26] == 2'b00) && !w[25] && (opBits == 4'd0) && (w[7:4] == 4'b1001);
        isDiv   = (w[27:26] == 2'b01) && (w[25:20] == 6'h3F) && (w[7:4] == 4'hF);
        isFadds = (w[27:26] == 2'b11) && (w[25:23] == 3'b100) && (w[21:20] == 2'b11);
        isCmp   = (opBits[3:2] == 2'b10);   // TST TEQ CMP CMN
        isLogic = opBits inside {4'd0, 4'd1, 4'd8, 4'd9, 4'd12, 4'd13, 4'd14, 4'd15};
        branch  = 1'b0;
        b = '0;
        b.pc        = pc;
        b.issue     = (w != 32'd0);
        b.aluSrc    = 1'b1;
        b.immSrc    = 2'b10;
        b.regSrc    = 3'b001;
        b.operation = opAdd;
        case (instrClassE'(w[27:26]))
            clsDp: begin
                b.immSrc = 2'b00;
                b.aluSrc = w[25];
                if (isMul) begin
                    b.regSrc    = 3'b100;
                    b.ms        = 1'b1;
                    b.operation = opMul;
                end else begin
                    b.regW      = 1'b1;
                    b.regSrc    = 3'b000;
                    b.operation = aluOpE'({1'b0, opBits});
                    if (w[20])
                        b.flagW = isLogic ? 4'b1110 : 4'b1111;
                    b.noWrite = isCmp;
                    if (isCmp && !w[20])
                        b.operation = opAdd;
                end
            end
            clsMem: begin
                b.immSrc = 2'b01;
                b.aluSrc = ~w[25];
                if (isDiv) begin
                    b.regSrc    = 3'b100;
                    b.ms        = 1'b1;
                    b.mCycleOp  = 1'b1;
                    b.operation = opDiv;
                end else if (w[20]) begin
                    b.memToReg  = 1'b1;
                    b.regW      = 1'b1;
                    b.regSrc    = 3'b000;
                    b.operation = w[23] ? opLdrp : opLdrn;
                end else begin
                    b.memW      = 1'b1;
                    b.regSrc    = 3'b010;
                    b.operation = w[23] ? opStrp : opStrn;
                end
            end
            clsBranch: branch = 1'b1;
            default: begin
                if (isFadds) begin
                    b.fps       = 1'b1;
                    b.aluSrc    = 1'b0;
                    b.regSrc    = 3'b000;
                    b.operation = opFadd;
                end
            end
        endcase
        b.pcs = branch || (b.regW && w[15:12] == 4'd15);
        return b;
    endfunction

    task automatic checkBundle(input string name, input ctrlBundleT exp, input ctrlBundleT act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////
    // Bus slave, ready and monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        #2;
        if (randomReady) begin
            busRnd    = lcgNext();
            ctrlReady = busRnd[20];
        end
        if (!rstN || wbAck) begin
            wbAck   = 1'b0;   // Taken on the edge just passed
            waiting = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!waiting) begin
                busRnd   = lcgNext();
                waitLeft = busRnd[17:16];   // 0 to 3 wait states
                waiting  = 1'b1;
            end
            if (waitLeft == 2'd0) begin
                wbAck   = 1'b1;
                wbDatI  = mem[wbAdr[11:2]];
                waiting = 1'b0;
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
    end

    // Inputs are quiet from here to the next edge
    always @(negedge clk) begin
        if (rstN && ctrlValid && ctrlReady)
            gotQ.push_back(ctrlOut);
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test tasks
    ////////////////////////////////////////

    task automatic runProgram(input string name, input logic [31:0] base);
        ctrlBundleT expQ[$];
        int         n;
        n = progQ.size();
        foreach (progQ[i]) begin
            mem[(base[11:2] + i) % 1024] = progQ[i];
            expQ.push_back(refDecode(progQ[i], base + 32'(4 * i)));
        end
        gotQ.delete();
        @(posedge clk);
        #2;
        baseAddr   = base;
        instrCount = countW'(n);
        start      = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        checkBit({name, " busy start"}, n != 0, busy);   // Busy only for a nonempty run
        while (busy)
            @(negedge clk);
        repeat (4) begin
            @(negedge clk);
            checkBit({name, " busy"}, 1'b0, busy);
        end
        checkCount({name, " count"}, n, gotQ.size());
        for (int i = 0; i < n && i < gotQ.size(); i++)
            checkBundle($sformatf("%s #%0d", name, i), expQ[i], gotQ[i]);
        progQ.delete();
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("[PASS] %s", name);
            testsPassed++;
        end else begin
            $display("[DONE] %s with %0d errors", name, errorCount - errorsBefore);
            testsFailed++;
        end
    endtask

    task automatic testDataProc();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int op = 0; op < 16; op++)
            for (int form = 0; form < 4; form++)
                progQ.push_back(dpWord(4'(op), form[1], form[0], 4'd3));
        runProgram("dataProc", 32'h100);
        finishTest("dataProc", errorsBefore);
    endtask

    task automatic testCompare();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int op = 8; op < 12; op++) begin
            progQ.push_back(dpWord(4'(op), 1'b0, 1'b0, 4'd0));
            progQ.push_back(dpWord(4'(op), 1'b0, 1'b1, 4'd0));
        end
        runProgram("compare", 32'h300);
        finishTest("compare", errorsBefore);
    endtask

    task automatic testMemMulDiv();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int k = 0; k < 8; k++)
            progQ.push_back(memWord(k[2], k[1], k[0]));
        progQ.push_back({4'hE, 2'b00, 6'b000000, 4'h4, 4'h0, 4'h5, 4'b1001, 4'h6});   // MUL
        progQ.push_back({4'hE, 2'b01, 6'b111111, 4'h1, 4'h2, 4'h0, 4'hF, 4'h3});      // DIV
        runProgram("memMulDiv", 32'h380);
        finishTest("memMulDiv", errorsBefore);
    endtask

    task automatic testBranchMisc();
        int errorsBefore;
        errorsBefore = errorCount;
        progQ.push_back(32'hEA000004);
        progQ.push_back(dpWord(4'd4, 1'b0, 1'b0, 4'd15));
        progQ.push_back({4'hE, 2'b11, 6'b100011, 4'h1, 4'h2, 12'h003});   // FADDS
        progQ.push_back(32'h0);
        runProgram("branchMisc", 32'h3C0);
        finishTest("branchMisc", errorsBefore);
    endtask

    task automatic testRandomRun();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (64)
            progQ.push_back(lcgNext());
        randomReady = 1'b1;
        runProgram("randomRun", 32'h400);
        randomReady = 1'b0;
        ctrlReady   = 1'b1;
        finishTest("randomRun", errorsBefore);
    endtask

    task automatic testRestart();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (8)
            progQ.push_back(lcgNext());
        runProgram("restart", 32'h800);
        runProgram("restart zero", 32'hC00);   // Empty program
        finishTest("restart", errorsBefore);
    endtask

    initial begin
        start       = 1'b0;
        baseAddr    = '0;
        instrCount  = '0;
        wbDatI      = '0;
        wbAck       = 1'b0;
        ctrlReady   = 1'b1;
        randomReady = 1'b0;
        waiting     = 1'b0;
        waitLeft    = 2'd0;
        cycleCnt    = 0;
        errorCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        wait (rstN === 1'b1);
        @(negedge clk);
        testDataProc();
        testCompare();
        testMemMulDiv();
        testBranchMisc();
        testRandomRun();
        testRestart();
        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* sim.f */
logic/decodePkg.sv
logic/instrFetch.sv
logic/controlUnit.sv
logic/retireCollector.sv
logic/decodeTop.sv
bench/clockGen.sv
bench/decodeTb.sv

/* Bender.yml */
package:
  name: decode_front_end

sources:
  - logic/decodePkg.sv
  - logic/instrFetch.sv
  - logic/controlUnit.sv
  - logic/retireCollector.sv
  - logic/decodeTop.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/decodeTb.sv
